// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Core geometry
    localparam int xlen           = 32;
    localparam int reg_count      = 32;
    localparam int reg_addr_width = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h30000000;

    // --------------------------------------------------
    // Major opcodes
    // --------------------------------------------------
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // Function codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // The only system instruction we accept
    localparam logic [31:0] inst_ebreak = 32'h00100073;

    // --------------------------------------------------
    // ALU operations and instruction kinds
    // --------------------------------------------------
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    localparam int kind_width = 3;

    localparam logic [kind_width-1:0] kind_alu_reg = 3'd0;
    localparam logic [kind_width-1:0] kind_alu_imm = 3'd1;
    localparam logic [kind_width-1:0] kind_lui     = 3'd2;
    localparam logic [kind_width-1:0] kind_beq     = 3'd3;
    localparam logic [kind_width-1:0] kind_bne     = 3'd4;
    localparam logic [kind_width-1:0] kind_jal     = 3'd5;
    localparam logic [kind_width-1:0] kind_ebreak  = 3'd6;

endpackage

`default_nettype wire

// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // AXI4 read channel widths
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Read response codes
    localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
`default_nettype none

module fetch_unit (
    input  logic                           clock,
    input  logic                           reset,
    // AXI4 read address channel
    output logic                           arvalid,
    input  logic                           arready,
    output logic [bus_pkg::addr_width-1:0] araddr,
    // AXI4 read data channel
    input  logic                           rvalid,
    output logic                           rready,
    input  logic [bus_pkg::data_width-1:0] rdata,
    input  logic [1:0]                     rresp,
    // Handoff to decode
    output logic                           fetch_valid,
    input  logic                           decode_ready,
    output logic [isa_pkg::xlen-1:0]       fetch_pc,
    output logic [isa_pkg::xlen-1:0]       fetch_inst,
    output logic                           fetch_error,
    // Next pc from execute
    input  logic                           resolve,
    input  logic                           redirect,
    input  logic [isa_pkg::xlen-1:0]       redirect_pc,
    input  logic                           halt_req
);

    import isa_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        st_request,
        st_wait_data,
        st_hold,
        st_wait_resolve,
        st_stopped
    } state_t;

    state_t          state;
    logic [xlen-1:0] pc;

    // Handshake outputs straight from the state
    assign arvalid     = (state == st_request);
    assign rready      = (state == st_wait_data);
    assign fetch_valid = (state == st_hold);
    assign araddr      = pc;
    assign fetch_pc    = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_request;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_request:
                    if (arready) state <= st_wait_data;
                st_wait_data:
                    if (rvalid) state <= st_hold;
                st_hold:
                    if (decode_ready) state <= st_wait_resolve;
                st_wait_resolve:
                    if (resolve) begin
                        if (halt_req) begin
                            state <= st_stopped;
                        end else begin
                            state <= st_request;
                            pc    <= redirect ? redirect_pc : pc + 32'd4;
                        end
                    end
                default:
                    state <= st_stopped;
            endcase
        end
    end

    // Instruction word and its response status
    always_ff @(posedge clock) begin
        if (state == st_wait_data && rvalid) begin
            fetch_inst  <= rdata;
            fetch_error <= (rresp != resp_okay);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode_unit.sv ====
`default_nettype none

module decode_unit (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 fetch_valid,
    output logic                                 decode_ready,
    input  logic [isa_pkg::xlen-1:0]             fetch_pc,
    input  logic [isa_pkg::xlen-1:0]             fetch_inst,
    input  logic                                 fetch_error,
    output logic [isa_pkg::reg_addr_width-1:0]   rs1_addr,
    output logic [isa_pkg::reg_addr_width-1:0]   rs2_addr,
    input  logic [isa_pkg::xlen-1:0]             rs1_data,
    input  logic [isa_pkg::xlen-1:0]             rs2_data,
    output logic                                 ex_valid,
    output logic [isa_pkg::xlen-1:0]             ex_pc,
    output isa_pkg::alu_op_t                     ex_alu_op,
    output logic [isa_pkg::xlen-1:0]             ex_a,
    output logic [isa_pkg::xlen-1:0]             ex_b,
    output logic [isa_pkg::xlen-1:0]             ex_imm,
    output logic [isa_pkg::reg_addr_width-1:0]   ex_rd,
    output logic                                 ex_we,
    output logic [isa_pkg::kind_width-1:0]       ex_kind,
    output logic                                 ex_illegal
);

    import isa_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [xlen-1:0]       imm_i, imm_u, imm_b, imm_j, imm;
    logic [kind_width-1:0] kind;
    alu_op_t               alu_op;
    logic                  we;
    logic                  bad_enc;
    logic                  handoff;

    assign opcode   = fetch_inst[6:0];
    assign funct3   = fetch_inst[14:12];
    assign funct7   = fetch_inst[31:25];
    assign rs1_addr = fetch_inst[19:15];
    assign rs2_addr = fetch_inst[24:20];

    // Immediate formats
    assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
    assign imm_u = {fetch_inst[31:12], 12'b0};
    assign imm_b = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
                    fetch_inst[11:8], 1'b0};
    assign imm_j = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
                    fetch_inst[30:21], 1'b0};

    always_comb begin
        kind    = kind_ebreak;
        alu_op  = alu_add;
        imm     = imm_i;
        we      = 1'b0;
        bad_enc = 1'b0;
        case (opcode)
            op_imm: begin
                kind    = kind_alu_imm;
                we      = 1'b1;
                bad_enc = (funct3 != f3_add_sub);
            end
            op_reg: begin
                kind = kind_alu_reg;
                we   = 1'b1;
                if (funct3 == f3_add_sub && funct7 == f7_base) alu_op = alu_add;
                else if (funct3 == f3_add_sub && funct7 == f7_sub) alu_op = alu_sub;
                else if (funct3 == f3_and && funct7 == f7_base) alu_op = alu_and;
                else if (funct3 == f3_or && funct7 == f7_base) alu_op = alu_or;
                else if (funct3 == f3_xor && funct7 == f7_base) alu_op = alu_xor;
                else bad_enc = 1'b1;
            end
            op_lui: begin
                kind   = kind_lui;
                alu_op = alu_pass_b;
                imm    = imm_u;
                we     = 1'b1;
            end
            op_branch: begin
                kind    = (funct3 == f3_bne) ? kind_bne : kind_beq;
                imm     = imm_b;
                bad_enc = (funct3 != f3_beq) && (funct3 != f3_bne);
            end
            op_jal: begin
                kind = kind_jal;
                imm  = imm_j;
                we   = 1'b1;
            end
            op_system: bad_enc = (fetch_inst != inst_ebreak);
            default:   bad_enc = 1'b1;
        endcase
    end

    // One instruction deep and drained the cycle after it arrives
    assign decode_ready = !ex_valid;
    assign handoff      = fetch_valid && decode_ready;

    always_ff @(posedge clock) begin
        if (reset) ex_valid <= 1'b0;
        else       ex_valid <= handoff;
    end

    always_ff @(posedge clock) begin
        if (handoff) begin
            ex_pc      <= fetch_pc;
            ex_alu_op  <= alu_op;
            ex_a       <= rs1_data;
            ex_b       <= rs2_data;
            ex_imm     <= imm;
            ex_rd      <= fetch_inst[11:7];
            ex_kind    <= kind;
            ex_illegal <= bad_enc || fetch_error;
            ex_we      <= we && !bad_enc && !fetch_error;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
`default_nettype none

module execute_unit (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               ex_valid,
    input  logic [isa_pkg::xlen-1:0]           ex_pc,
    input  isa_pkg::alu_op_t                   ex_alu_op,
    input  logic [isa_pkg::xlen-1:0]           ex_a,
    input  logic [isa_pkg::xlen-1:0]           ex_b,
    input  logic [isa_pkg::xlen-1:0]           ex_imm,
    input  logic [isa_pkg::reg_addr_width-1:0] ex_rd,
    input  logic                               ex_we,
    input  logic [isa_pkg::kind_width-1:0]     ex_kind,
    input  logic                               ex_illegal,
    output logic                               resolve,
    output logic                               redirect,
    output logic [isa_pkg::xlen-1:0]           redirect_pc,
    output logic                               halt_req,
    output logic                               wb_valid,
    output logic [isa_pkg::xlen-1:0]           wb_pc,
    output logic [isa_pkg::reg_addr_width-1:0] wb_rd,
    output logic                               wb_we,
    output logic [isa_pkg::xlen-1:0]           wb_data,
    output logic                               illegal
);

    import isa_pkg::*;

    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] result;
    logic            taken;
    logic            wb_illegal;

    // Second operand is rs2 only for register-register ops
    assign operand_b = (ex_kind == kind_alu_reg) ? ex_b : ex_imm;

    always_comb begin
        case (ex_alu_op)
            alu_sub:    alu_out = ex_a - operand_b;
            alu_and:    alu_out = ex_a & operand_b;
            alu_or:     alu_out = ex_a | operand_b;
            alu_xor:    alu_out = ex_a ^ operand_b;
            alu_pass_b: alu_out = operand_b;
            default:    alu_out = ex_a + operand_b;
        endcase
    end

    // jal links pc+4 and everything else writes the ALU output
    assign result = (ex_kind == kind_jal) ? ex_pc + 32'd4 : alu_out;

    assign taken = (ex_kind == kind_jal)
                || (ex_kind == kind_beq && ex_a == ex_b)
                || (ex_kind == kind_bne && ex_a != ex_b);

    always_ff @(posedge clock) begin
        if (reset) begin
            resolve  <= 1'b0;
            wb_valid <= 1'b0;
            halt_req <= 1'b0;
        end else begin
            resolve  <= ex_valid;
            wb_valid <= ex_valid;
            halt_req <= ex_valid && (ex_illegal || ex_kind == kind_ebreak);
        end
    end

    always_ff @(posedge clock) begin
        if (ex_valid) begin
            redirect    <= taken && !ex_illegal;
            redirect_pc <= ex_pc + ex_imm;
            wb_pc       <= ex_pc;
            wb_rd       <= ex_rd;
            wb_we       <= ex_we;
            wb_data     <= result;
            wb_illegal  <= ex_illegal;
        end
    end

    // Sticky and lined up with the halting commit
    always_ff @(posedge clock) begin
        if (reset) illegal <= 1'b0;
        else if (wb_valid && wb_illegal) illegal <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/result_unit.sv ====
`default_nettype none

module result_unit (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               wb_valid,
    input  logic [isa_pkg::xlen-1:0]           wb_pc,
    input  logic [isa_pkg::reg_addr_width-1:0] wb_rd,
    input  logic                               wb_we,
    input  logic [isa_pkg::xlen-1:0]           wb_data,
    input  logic                               halt_req,
    input  logic [isa_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [isa_pkg::reg_addr_width-1:0] rs2_addr,
    output logic [isa_pkg::xlen-1:0]           rs1_data,
    output logic [isa_pkg::xlen-1:0]           rs2_data,
    output logic                               commit_valid,
    output logic [isa_pkg::xlen-1:0]           commit_pc,
    output logic [isa_pkg::reg_addr_width-1:0] commit_rd,
    output logic [isa_pkg::xlen-1:0]           commit_data,
    output logic                               halted
);

    import isa_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:reg_count-1];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < reg_count; i++) regs[i] <= '0;
        end else if (wb_valid && wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // --------------------------------------------------
    // Commit report
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            commit_valid <= wb_valid;
            if (wb_valid && halt_req) halted <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wb_valid) begin
            commit_pc   <= wb_pc;
            commit_rd   <= wb_we ? wb_rd : '0;
            commit_data <= wb_we ? wb_data : '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/core_top.sv ====
`default_nettype none

module core_top (
    input  logic                               clock,
    input  logic                               reset,
    output logic                               arvalid,
    input  logic                               arready,
    output logic [bus_pkg::addr_width-1:0]     araddr,
    input  logic                               rvalid,
    output logic                               rready,
    input  logic [bus_pkg::data_width-1:0]     rdata,
    input  logic [1:0]                         rresp,
    output logic                               commit_valid,
    output logic [isa_pkg::xlen-1:0]           commit_pc,
    output logic [isa_pkg::reg_addr_width-1:0] commit_rd,
    output logic [isa_pkg::xlen-1:0]           commit_data,
    output logic                               halted,
    output logic                               illegal
);

    import isa_pkg::*;

    // Fetch to decode
    logic                      fetch_valid, decode_ready, fetch_error;
    logic [xlen-1:0]           fetch_pc, fetch_inst;
    // Execute to fetch
    logic                      resolve, redirect, halt_req;
    logic [xlen-1:0]           redirect_pc;
    // Decode to execute
    logic                      ex_valid, ex_we, ex_illegal;
    logic [xlen-1:0]           ex_pc, ex_a, ex_b, ex_imm;
    alu_op_t                   ex_alu_op;
    logic [reg_addr_width-1:0] ex_rd;
    logic [kind_width-1:0]     ex_kind;
    // Execute to result, register reads
    logic                      wb_valid, wb_we;
    logic [xlen-1:0]           wb_pc, wb_data, rs1_data, rs2_data;
    logic [reg_addr_width-1:0] wb_rd, rs1_addr, rs2_addr;

    fetch_unit fetch_i (.*);

    decode_unit decode_i (.*);

    execute_unit execute_i (.*);

    result_unit result_i (.*);

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clock
);

    // Period of 4 time units
    localparam int half_period = 2;

    initial clock = 1'b0;

    always #half_period clock = ~clock;

endmodule

`default_nettype wire

// ==== testbench/core_props.sv ====
`default_nettype none

module core_props (
    input logic        clock,
    input logic        reset,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        rvalid,
    input logic        rready,
    input logic        commit_valid,
    input logic        halted
);

    int violation_count = 0;

    // --------------------------------------------------
    // AXI read channel
    // --------------------------------------------------
    ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            violation_count++;
            $error("arvalid dropped or araddr changed before arready");
        end

    ar_aligned: assert property (@(posedge clock) disable iff (reset)
        arvalid |-> araddr[1:0] == 2'b00)
        else begin
            violation_count++;
            $error("araddr is not word aligned");
        end

    // Slave only presents data while the core waits for it
    r_ready: assert property (@(posedge clock) disable iff (reset)
        rvalid |-> rready)
        else begin
            violation_count++;
            $error("r beat presented while rready is low");
        end

    // Commit port
    no_commit_after_halt: assert property (@(posedge clock) disable iff (reset)
        halted |=> !commit_valid)
        else begin
            violation_count++;
            $error("commit seen after the core halted");
        end

endmodule

bind core_top core_props props_i (.*);

`default_nettype wire

// ==== testbench/core_tb.sv ====
`default_nettype none

module core_tb;

    import isa_pkg::*;

    localparam int reset_cycles = 16;
    localparam int quiet_cycles = 20;
    localparam int worst_cpi    = 16;
    localparam int max_words    = 32;
    localparam int s_addr       = 0;
    localparam int s_delay      = 1;
    localparam int s_data       = 2;

    localparam logic [31:0] ebreak_word = 32'h00100073;

    logic        clock;
    logic        reset;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] araddr, rdata;
    logic [1:0]  rresp;
    logic        commit_valid, halted, illegal;
    logic [31:0] commit_pc, commit_data;
    logic [4:0]  commit_rd;

    // Program words and expected outcome per run segment
    logic [31:0] prog_words  [0:1][0:max_words-1];
    int          prog_len    [0:1];
    int          seg_rows    [0:1];
    logic        seg_illegal [0:1];

    // Expected commits as pc offset from reset_pc, rd and data
    logic [31:0] exp_off[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];

    int          segment, row, row_first, row_end;
    int          reads, beats, wait_count, slave_state;
    int          cycles, cycle_limit;
    logic [31:0] req_addr;
    logic [31:0] rand_state = 32'hd1f7c642;

    clock_gen clock_i (.clock(clock));

    core_top dut_i (.*);

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // RV32I encodings
    function automatic logic [31:0] itype_word(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] btype_word(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_inst(input int seg, input logic [31:0] word);
        prog_words[seg][prog_len[seg]] = word;
        prog_len[seg]++;
    endtask

    task automatic add_commit(input int seg, input logic [31:0] off, input logic [4:0] rd,
                              input logic [31:0] data);
        exp_off.push_back(off);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        seg_rows[seg]++;
    endtask

    // Words past the end of a program read as ebreak
    function automatic logic [31:0] memory_word(input int seg, input logic [31:0] addr);
        logic [31:0] index;
        index = (addr - reset_pc) >> 2;
        if (addr >= reset_pc && index < prog_len[seg]) begin
            return prog_words[seg][index];
        end
        return ebreak_word;
    endfunction

    task automatic load_tables();
        // Segment 0 covers ALU ops, x0, branches and jal before an ebreak at 0x48
        add_inst(0, itype_word(5'd1, 5'd0, 12'd5));
        add_inst(0, itype_word(5'd2, 5'd0, 12'hffd));
        add_inst(0, rtype_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        add_inst(0, rtype_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        add_inst(0, rtype_word(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        add_inst(0, rtype_word(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        add_inst(0, rtype_word(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        add_inst(0, {20'h12345, 5'd8, 7'b0110111});
        add_inst(0, itype_word(5'd0, 5'd1, 12'd7));
        add_inst(0, rtype_word(7'h00, 3'b000, 5'd9, 5'd0, 5'd1));
        add_inst(0, btype_word(3'b000, 5'd1, 5'd9, 13'd8));
        add_inst(0, itype_word(5'd10, 5'd0, 12'd99));
        add_inst(0, btype_word(3'b001, 5'd1, 5'd9, 13'd8));
        add_inst(0, btype_word(3'b001, 5'd1, 5'd2, 13'd8));
        add_inst(0, itype_word(5'd10, 5'd0, 12'd99));
        add_inst(0, btype_word(3'b000, 5'd1, 5'd2, 13'd8));
        add_inst(0, jtype_word(5'd11, 21'd8));
        add_inst(0, itype_word(5'd10, 5'd0, 12'd99));
        // Segment 1 halts with illegal on an unknown opcode
        add_inst(1, itype_word(5'd1, 5'd0, 12'd1));
        add_inst(1, rtype_word(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
        add_inst(1, 32'hffffffff);

        add_commit(0, 32'h00, 5'd1, 32'd5);
        add_commit(0, 32'h04, 5'd2, 32'hfffffffd);
        add_commit(0, 32'h08, 5'd3, 32'd2);
        add_commit(0, 32'h0c, 5'd4, 32'd8);
        add_commit(0, 32'h10, 5'd5, 32'd5);
        add_commit(0, 32'h14, 5'd6, 32'hfffffffd);
        add_commit(0, 32'h18, 5'd7, 32'hfffffff8);
        add_commit(0, 32'h1c, 5'd8, 32'h12345000);
        add_commit(0, 32'h20, 5'd0, 32'd12);
        add_commit(0, 32'h24, 5'd9, 32'd5);
        add_commit(0, 32'h28, 5'd0, 32'd0);
        add_commit(0, 32'h30, 5'd0, 32'd0);
        add_commit(0, 32'h34, 5'd0, 32'd0);
        add_commit(0, 32'h3c, 5'd0, 32'd0);
        add_commit(0, 32'h40, 5'd11, reset_pc + 32'h44);
        add_commit(0, 32'h48, 5'd0, 32'd0);
        add_commit(1, 32'h00, 5'd1, 32'd1);
        add_commit(1, 32'h04, 5'd2, 32'd2);
        add_commit(1, 32'h08, 5'd0, 32'd0);
        seg_illegal[0] = 1'b0;
        seg_illegal[1] = 1'b1;
    endtask

    // --------------------------------------------------
    // AXI read slave with random latency
    // --------------------------------------------------
    always @(posedge clock) begin
        if (reset) begin
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            slave_state <= s_addr;
            wait_count  <= 0;
            reads       <= 0;
            beats       <= 0;
        end else begin
            case (slave_state)
                s_addr:
                    if (arvalid && arready) begin
                        assert (reads > 0 || araddr == reset_pc)
                            else abort_run($sformatf("CHECK FAILED at %0t: first araddr %h",
                                                     $time, araddr));
                        arready     <= 1'b0;
                        req_addr    <= araddr;
                        reads       <= reads + 1;
                        rand_state = xorshift32(rand_state);
                        wait_count  <= rand_state[1:0];
                        slave_state <= s_delay;
                    end else if (arvalid) begin
                        if (wait_count == 0) begin
                            arready <= 1'b1;
                        end else begin
                            wait_count <= wait_count - 1;
                        end
                    end
                s_delay:
                    if (wait_count == 0) begin
                        rvalid      <= 1'b1;
                        rdata       <= memory_word(segment, req_addr);
                        rresp       <= 2'b00;
                        slave_state <= s_data;
                    end else begin
                        wait_count <= wait_count - 1;
                    end
                default:
                    if (rvalid && rready) begin
                        rvalid      <= 1'b0;
                        beats       <= beats + 1;
                        rand_state = xorshift32(rand_state);
                        wait_count  <= rand_state[1:0];
                        slave_state <= s_addr;
                    end
            endcase
        end
    end

    // --------------------------------------------------
    // Commit checks against the expected table
    // --------------------------------------------------
    always @(posedge clock) begin
        if (reset) begin
            row <= row_first;
        end else if (commit_valid) begin
            assert (row < row_end)
                else abort_run($sformatf("CHECK FAILED at %0t: extra commit at pc %h",
                                         $time, commit_pc));
            assert (beats > row - row_first)
                else abort_run($sformatf("CHECK FAILED at %0t: commit %0d before its read",
                                         $time, row));
            assert (commit_pc == reset_pc + exp_off[row] && commit_rd == exp_rd[row]
                    && commit_data == exp_data[row])
                else abort_run($sformatf(
                    "CHECK FAILED at %0t: commit %0d pc %h rd %0d data %h, expected %h %0d %h",
                    $time, row, commit_pc, commit_rd, commit_data,
                    reset_pc + exp_off[row], exp_rd[row], exp_data[row]));
            assert (halted == (row == row_end - 1)
                    && illegal == (row == row_end - 1 && seg_illegal[segment]))
                else abort_run($sformatf("CHECK FAILED at %0t: commit %0d halted %b illegal %b",
                                         $time, row, halted, illegal));
            row <= row + 1;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles: the core never halted", cycles));
        end
    end

    initial begin
        reset   = 1'b1;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        load_tables();
        cycle_limit = exp_off.size() * worst_cpi + 2 * (reset_cycles + quiet_cycles) + 100;

        for (int seg = 0; seg < 2; seg++) begin
            @(posedge clock);
            reset     <= 1'b1;
            segment   <= seg;
            row_first <= (seg == 0) ? 0 : seg_rows[0];
            row_end   <= (seg == 0) ? seg_rows[0] : seg_rows[0] + seg_rows[1];
            repeat (reset_cycles) @(posedge clock);
            reset <= 1'b0;
            while (row < row_end) @(posedge clock);
            // Core must stay halted with no new reads
            repeat (quiet_cycles) begin
                @(posedge clock);
                assert (!arvalid && halted && illegal == seg_illegal[seg])
                    else abort_run($sformatf(
                        "CHECK FAILED at %0t: after halt arvalid %b halted %b illegal %b",
                        $time, arvalid, halted, illegal));
            end
        end

        if (dut_i.props_i.violation_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/isa_pkg.sv
common/bus_pkg.sv
fetch/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/result_unit.sv
verilog/core_top.sv
testbench/clock_gen.sv
testbench/core_props.sv
testbench/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_axi_core

sources:
  - common/isa_pkg.sv
  - common/bus_pkg.sv
  - fetch/fetch_unit.sv
  - verilog/decode_unit.sv
  - verilog/execute_unit.sv
  - verilog/result_unit.sv
  - verilog/core_top.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/core_props.sv
      - testbench/core_tb.sv
